/* logic/exe_pkg.sv */
// ------------------------------------------------------------
// Execute stage package
// Data widths, unit selector, operation codes and exception
// causes shared by the steering, unit and writeback blocks
// ------------------------------------------------------------

package exe_pkg;

    localparam int XLEN       = 64;  // Data and address width
    localparam int REG_ADDR_W = 5;   // Destination register index
    localparam int N_UNITS    = 2;   // Peers on the writeback port

    // Functional unit selector, doubles as arbiter index
    typedef enum logic [0:0] {
        UNIT_ALU    = 1'b0,
        UNIT_BRANCH = 1'b1
    } unit_t;

    // ------------------------------------------------------------
    // Operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        JAL     = 4'd0,   // Jump and link
        JALR    = 4'd1,   // Jump to rs1 + imm
        BEQ     = 4'd2,
        BNE     = 4'd3,
        BLT     = 4'd4,
        BGE     = 4'd5,
        BLTU    = 4'd6,
        BGEU    = 4'd7,
        OP_ADD  = 4'd8,   // First ALU code
        OP_SUB  = 4'd9,
        OP_AND  = 4'd10,
        OP_OR   = 4'd11,
        OP_XOR  = 4'd12,
        OP_SLT  = 4'd13,
        OP_SLTU = 4'd14
    } op_t;

    // Exception causes, numbered as in mcause
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        NONE                  = 4'd15   // No exception raised
    } ex_cause_t;

endpackage

/* logic/issue_steer.sv */
// ------------------------------------------------------------
// Issue steering
// Runs the four-phase issue handshake and sends a one-cycle
// load pulse to the unit named by the unit field
// ------------------------------------------------------------
`timescale 1ns/1ps

module issue_steer
    import exe_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  issue_req_i,
    input  unit_t issue_unit_i,
    input  logic  alu_busy_i,
    input  logic  br_busy_i,
    output logic  issue_ack_o,
    output logic  alu_load_o,
    output logic  br_load_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,     // Load pulse to the chosen unit
        ST_ACKED     // Ack high, waiting for req low
    } state_t;

    state_t state_q;
    unit_t  unit_q;       // Unit chosen for the current instruction
    logic   target_busy;

    // Back-pressure from the addressed unit only
    assign target_busy = (issue_unit_i == UNIT_BRANCH) ? br_busy_i : alu_busy_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            unit_q  <= UNIT_ALU;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (issue_req_i && !target_busy) begin
                        state_q <= ST_LOAD;
                        unit_q  <= issue_unit_i;
                    end
                end
                ST_LOAD: state_q <= ST_ACKED;
                ST_ACKED: begin
                    if (!issue_req_i) begin
                        state_q <= ST_IDLE;   // Ack drops next cycle
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign alu_load_o  = (state_q == ST_LOAD) && (unit_q == UNIT_ALU);
    assign br_load_o   = (state_q == ST_LOAD) && (unit_q == UNIT_BRANCH);
    assign issue_ack_o = (state_q == ST_ACKED);

endmodule

/* logic/branch_unit.sv */
// ------------------------------------------------------------
// Branch unit
// Resolves jumps and conditional branches: taken flag, target,
// link value and target misalignment, then requests writeback
// ------------------------------------------------------------
`timescale 1ns/1ps

module branch_unit
    import exe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  load_i,
    input  op_t                   op_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic                  ack_i,
    output logic                  busy_o,
    output logic                  req_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  we_o,
    output logic [XLEN-1:0]       data_o,
    output logic [XLEN-1:0]       target_o,
    output logic                  taken_o,
    output logic                  ex_valid_o,
    output ex_cause_t             ex_cause_o,
    output logic [XLEN-1:0]       ex_origin_o
);

    typedef enum logic [1:0] {
        U_IDLE,
        U_EVAL,   // Operands held, results settle
        U_REQ,    // Waiting for ack
        U_REL     // Req dropped, waiting for ack low
    } state_t;

    state_t          state_q;
    op_t             op_q;
    logic [XLEN-1:0] pc_q, imm_q, rs1_q, rs2_q;

    logic            equal, less, less_u;
    logic            taken;
    logic            cond_branch;
    logic [XLEN-1:0] target, link, next_pc;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= U_IDLE;
        end else begin
            case (state_q)
                U_IDLE:  if (load_i) state_q <= U_EVAL;
                U_EVAL:  state_q <= U_REQ;
                U_REQ:   if (ack_i) state_q <= U_REL;
                U_REL:   if (!ack_i) state_q <= U_IDLE;
                default: state_q <= U_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q != U_IDLE);
    assign req_o  = (state_q == U_REQ);

    // Instruction capture on the load pulse
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            op_q  <= op_i;
            pc_q  <= pc_i;
            imm_q <= imm_i;
            rs1_q <= rs1_data_i;
            rs2_q <= rs2_data_i;
            rd_o  <= rd_i;
            we_o  <= we_i;
        end
    end

    // ------------------------------------------------------------
    // Evaluation
    // ------------------------------------------------------------
    assign equal  = (rs1_q == rs2_q);
    assign less   = $signed(rs1_q) < $signed(rs2_q);
    assign less_u = rs1_q < rs2_q;

    always_comb begin
        case (op_q)
            JAL, JALR: taken = 1'b1;
            BEQ:       taken = equal;
            BNE:       taken = !equal;
            BLT:       taken = less;
            BGE:       taken = !less;
            BLTU:      taken = less_u;
            BGEU:      taken = !less_u;
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op_q)
            JAL:     target = (pc_q + imm_q) & ~64'd1;   // Jumps clear bit 0
            JALR:    target = (rs1_q + imm_q) & ~64'd1;
            default: target = pc_q + imm_q;
        endcase
    end

    assign cond_branch = (op_q inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
    assign link        = pc_q + 64'd4;
    assign next_pc     = taken ? target : link;

    // Results registered once, held through the handshake
    always_ff @(posedge clk_i) begin
        if (state_q == U_EVAL) begin
            data_o      <= link;
            target_o    <= target;
            taken_o     <= taken;
            ex_origin_o <= next_pc;
            if ((next_pc[1:0] != 2'b00) && ((op_q == JALR) || (cond_branch && taken))) begin
                ex_valid_o <= 1'b1;
                ex_cause_o <= INSTR_ADDR_MISALIGNED;
            end else begin
                ex_valid_o <= 1'b0;
                ex_cause_o <= NONE;
            end
        end
    end

endmodule

/* logic/alu_unit.sv */
// ------------------------------------------------------------
// ALU unit
// Computes one integer operation on load and holds the result
// until the writeback arbiter has taken it
// ------------------------------------------------------------
`timescale 1ns/1ps

module alu_unit
    import exe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  load_i,
    input  op_t                   op_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic                  ack_i,
    output logic                  busy_o,
    output logic                  req_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  we_o,
    output logic [XLEN-1:0]       data_o
);

    typedef enum logic [1:0] {
        U_IDLE,
        U_DONE,   // Result registered
        U_REQ,
        U_REL     // Waiting for ack low
    } state_t;

    state_t          state_q;
    logic [XLEN-1:0] result;

    always_comb begin
        case (op_i)
            OP_ADD:  result = rs1_data_i + rs2_data_i;
            OP_SUB:  result = rs1_data_i - rs2_data_i;
            OP_AND:  result = rs1_data_i & rs2_data_i;
            OP_OR:   result = rs1_data_i | rs2_data_i;
            OP_XOR:  result = rs1_data_i ^ rs2_data_i;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(rs2_data_i)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, rs1_data_i < rs2_data_i};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            data_o <= result;
            rd_o   <= rd_i;
            we_o   <= we_i;
        end
    end

    // Same request and release sequence as the branch unit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= U_IDLE;
        end else begin
            case (state_q)
                U_IDLE:  if (load_i) state_q <= U_DONE;
                U_DONE:  state_q <= U_REQ;
                U_REQ:   if (ack_i) state_q <= U_REL;
                U_REL:   if (!ack_i) state_q <= U_IDLE;
                default: state_q <= U_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q != U_IDLE);
    assign req_o  = (state_q == U_REQ);

endmodule

/* logic/wb_arbiter.sv */
// ------------------------------------------------------------
// Writeback arbiter
// Round-robin grant of the single writeback port, bridging
// each unit's four-phase handshake to the outside one
// ------------------------------------------------------------
`timescale 1ns/1ps

module wb_arbiter
    import exe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [N_UNITS-1:0]    unit_req_i,
    input  logic [REG_ADDR_W-1:0] rd_i        [N_UNITS],
    input  logic                  we_i        [N_UNITS],
    input  logic [XLEN-1:0]       data_i      [N_UNITS],
    input  logic [XLEN-1:0]       target_i    [N_UNITS],
    input  logic                  taken_i     [N_UNITS],
    input  logic                  ex_valid_i  [N_UNITS],
    input  ex_cause_t             ex_cause_i  [N_UNITS],
    input  logic [XLEN-1:0]       ex_origin_i [N_UNITS],
    input  logic                  wb_ack_i,
    output logic [N_UNITS-1:0]    unit_ack_o,
    output logic                  wb_req_o,
    output unit_t                 wb_unit_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic                  wb_we_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_target_o,
    output logic                  wb_taken_o,
    output logic                  wb_ex_valid_o,
    output ex_cause_t             wb_ex_cause_o,
    output logic [XLEN-1:0]       wb_ex_origin_o
);

    typedef enum logic [2:0] {
        A_IDLE,
        A_GRANT,   // Fields registered
        A_REQ,     // wb_req_o high, waiting for wb_ack_i
        A_ACK,     // Unit acked, waiting for its req low
        A_DROP     // wb_req_o low, waiting for wb_ack_i low
    } state_t;

    state_t state_q;
    unit_t  grant_q;
    unit_t  last_q;    // Unit served last
    unit_t  pick;
    logic   any_req;
    logic   ack_phase;

    assign any_req = |unit_req_i;

    // ALU wins unless only branch asks or ALU went last
    always_comb begin
        if (unit_req_i[UNIT_ALU] && (!unit_req_i[UNIT_BRANCH] || last_q == UNIT_BRANCH)) begin
            pick = UNIT_ALU;
        end else begin
            pick = UNIT_BRANCH;
        end
    end

    // ------------------------------------------------------------
    // Grant and handshake bridge
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= A_IDLE;
            grant_q <= UNIT_ALU;
            last_q  <= UNIT_BRANCH;   // ALU first after reset
        end else begin
            case (state_q)
                A_IDLE: begin
                    if (any_req) begin
                        grant_q <= pick;
                        last_q  <= pick;
                        state_q <= A_GRANT;
                    end
                end
                A_GRANT: state_q <= A_REQ;
                A_REQ:   if (wb_ack_i) state_q <= A_ACK;
                A_ACK:   if (!unit_req_i[grant_q]) state_q <= A_DROP;
                A_DROP:  if (!wb_ack_i) state_q <= A_IDLE;
                default: state_q <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == A_IDLE && any_req) begin
            wb_rd_o        <= rd_i[pick];
            wb_we_o        <= we_i[pick];
            wb_data_o      <= data_i[pick];
            wb_target_o    <= target_i[pick];
            wb_taken_o     <= taken_i[pick];
            wb_ex_valid_o  <= ex_valid_i[pick];
            wb_ex_cause_o  <= ex_cause_i[pick];
            wb_ex_origin_o <= ex_origin_i[pick];
        end
    end

    assign wb_unit_o = grant_q;
    assign wb_req_o  = (state_q == A_REQ) || (state_q == A_ACK);
    assign ack_phase = (state_q == A_ACK) || (state_q == A_DROP);

    always_comb begin
        for (int i = 0; i < N_UNITS; i++) begin
            unit_ack_o[i] = ack_phase && (int'(grant_q) == i);
        end
    end

endmodule

/* logic/exe_top.sv */
// ------------------------------------------------------------
// Execute and writeback top
// Steering, branch and ALU units, and the writeback arbiter
// ------------------------------------------------------------
`timescale 1ns/1ps

module exe_top
    import exe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Issue port
    input  logic                  issue_req_i,
    output logic                  issue_ack_o,
    input  unit_t                 issue_unit_i,
    input  op_t                   issue_op_i,
    input  logic [XLEN-1:0]       issue_pc_i,
    input  logic [XLEN-1:0]       issue_imm_i,
    input  logic [XLEN-1:0]       issue_rs1_data_i,
    input  logic [XLEN-1:0]       issue_rs2_data_i,
    input  logic [REG_ADDR_W-1:0] issue_rd_i,
    input  logic                  issue_we_i,
    // Writeback port
    output logic                  wb_req_o,
    input  logic                  wb_ack_i,
    output unit_t                 wb_unit_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic                  wb_we_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_target_o,
    output logic                  wb_taken_o,
    output logic                  wb_ex_valid_o,
    output ex_cause_t             wb_ex_cause_o,
    output logic [XLEN-1:0]       wb_ex_origin_o
);

    logic                  alu_load, br_load;
    logic                  alu_busy, br_busy;
    logic [N_UNITS-1:0]    unit_req, unit_ack;

    // Per-unit writeback fields
    logic [REG_ADDR_W-1:0] rd        [N_UNITS];
    logic                  we        [N_UNITS];
    logic [XLEN-1:0]       data      [N_UNITS];
    logic [XLEN-1:0]       target    [N_UNITS];
    logic                  taken     [N_UNITS];
    logic                  ex_valid  [N_UNITS];
    ex_cause_t             ex_cause  [N_UNITS];
    logic [XLEN-1:0]       ex_origin [N_UNITS];

    issue_steer issue_steer_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .issue_req_i  (issue_req_i),
        .issue_unit_i (issue_unit_i),
        .alu_busy_i   (alu_busy),
        .br_busy_i    (br_busy),
        .issue_ack_o  (issue_ack_o),
        .alu_load_o   (alu_load),
        .br_load_o    (br_load)
    );

    branch_unit branch_unit_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .load_i      (br_load),
        .op_i        (issue_op_i),
        .pc_i        (issue_pc_i),
        .imm_i       (issue_imm_i),
        .rs1_data_i  (issue_rs1_data_i),
        .rs2_data_i  (issue_rs2_data_i),
        .rd_i        (issue_rd_i),
        .we_i        (issue_we_i),
        .ack_i       (unit_ack[UNIT_BRANCH]),
        .busy_o      (br_busy),
        .req_o       (unit_req[UNIT_BRANCH]),
        .rd_o        (rd[UNIT_BRANCH]),
        .we_o        (we[UNIT_BRANCH]),
        .data_o      (data[UNIT_BRANCH]),
        .target_o    (target[UNIT_BRANCH]),
        .taken_o     (taken[UNIT_BRANCH]),
        .ex_valid_o  (ex_valid[UNIT_BRANCH]),
        .ex_cause_o  (ex_cause[UNIT_BRANCH]),
        .ex_origin_o (ex_origin[UNIT_BRANCH])
    );

    alu_unit alu_unit_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .load_i     (alu_load),
        .op_i       (issue_op_i),
        .rs1_data_i (issue_rs1_data_i),
        .rs2_data_i (issue_rs2_data_i),
        .rd_i       (issue_rd_i),
        .we_i       (issue_we_i),
        .ack_i      (unit_ack[UNIT_ALU]),
        .busy_o     (alu_busy),
        .req_o      (unit_req[UNIT_ALU]),
        .rd_o       (rd[UNIT_ALU]),
        .we_o       (we[UNIT_ALU]),
        .data_o     (data[UNIT_ALU])
    );

    // ALU has no branch or exception results
    assign target[UNIT_ALU]    = '0;
    assign taken[UNIT_ALU]     = 1'b0;
    assign ex_valid[UNIT_ALU]  = 1'b0;
    assign ex_cause[UNIT_ALU]  = NONE;
    assign ex_origin[UNIT_ALU] = '0;

    wb_arbiter wb_arbiter_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .unit_req_i     (unit_req),
        .rd_i           (rd),
        .we_i           (we),
        .data_i         (data),
        .target_i       (target),
        .taken_i        (taken),
        .ex_valid_i     (ex_valid),
        .ex_cause_i     (ex_cause),
        .ex_origin_i    (ex_origin),
        .wb_ack_i       (wb_ack_i),
        .unit_ack_o     (unit_ack),
        .wb_req_o       (wb_req_o),
        .wb_unit_o      (wb_unit_o),
        .wb_rd_o        (wb_rd_o),
        .wb_we_o        (wb_we_o),
        .wb_data_o      (wb_data_o),
        .wb_target_o    (wb_target_o),
        .wb_taken_o     (wb_taken_o),
        .wb_ex_valid_o  (wb_ex_valid_o),
        .wb_ex_cause_o  (wb_ex_cause_o),
        .wb_ex_origin_o (wb_ex_origin_o)
    );

endmodule

/* testbench/tb_exe_top.sv */
// ------------------------------------------------------------
// Execute stage testbench
// Random ALU and branch instructions over the issue port, a
// writeback responder with random back-pressure, and per-unit
// reference queues checked against every writeback
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_exe_top
    import exe_pkg::*;
();

    localparam int          N_INSTR = 300;
    localparam int          TIMEOUT = 200;   // Cycles per wait
    localparam int          QUIET   = 20;    // Idle cycles watched after the last writeback
    localparam logic [31:0] SEED    = 32'h58a1;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       target;
        logic                  taken;
        logic                  ex_valid;
        logic [XLEN-1:0]       origin;
    } exp_t;

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    logic                  issue_req_i, issue_ack_o, issue_we_i;
    unit_t                 issue_unit_i;
    op_t                   issue_op_i;
    logic [XLEN-1:0]       issue_pc_i, issue_imm_i, issue_rs1_data_i, issue_rs2_data_i;
    logic [REG_ADDR_W-1:0] issue_rd_i;
    logic                  wb_req_o, wb_ack_i, wb_we_o, wb_taken_o, wb_ex_valid_o;
    unit_t                 wb_unit_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o, wb_target_o, wb_ex_origin_o;
    ex_cause_t             wb_ex_cause_o;

    logic [31:0] rng_state = SEED;
    exp_t        alu_q[$];
    exp_t        br_q[$];
    int          wb_count = 0;
    logic        extra_wb = 1'b0;

    exe_top exe_top_inst (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Error reporting and random numbers
    // ------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got, exp);
        report_error($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Boundary values mixed in with plain random words
    function automatic logic [XLEN-1:0] pick_operand();
        logic [31:0] sel;
        sel = next_rand();
        case (sel[2:0])
            3'd0:    return 64'h8000_0000_0000_0000;
            3'd1:    return 64'h7fff_ffff_ffff_ffff;
            3'd2:    return '1;
            3'd3:    return '0;
            default: return {next_rand(), next_rand()};
        endcase
    endfunction

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic exp_t alu_model(input op_t op, input logic [XLEN-1:0] a, b,
                                       input logic [REG_ADDR_W-1:0] rd, input logic we);
        exp_t e;
        e = '0;
        e.rd = rd;
        e.we = we;
        case (op)
            OP_ADD:  e.data = a + b;
            OP_SUB:  e.data = a - b;
            OP_AND:  e.data = a & b;
            OP_OR:   e.data = a | b;
            OP_XOR:  e.data = a ^ b;
            OP_SLT:  e.data = {63'd0, $signed(a) < $signed(b)};
            default: e.data = {63'd0, a < b};
        endcase
        return e;
    endfunction

    function automatic exp_t branch_model(input op_t op, input logic [XLEN-1:0] pc, imm, a, b,
                                          input logic [REG_ADDR_W-1:0] rd, input logic we);
        exp_t            e;
        logic            is_cond;
        logic [XLEN-1:0] sum, next;
        is_cond = (op != JAL) && (op != JALR);
        sum     = (op == JALR) ? a + imm : pc + imm;
        case (op)
            BEQ:     e.taken = (a == b);
            BNE:     e.taken = (a != b);
            BLT:     e.taken = $signed(a) < $signed(b);
            BGE:     e.taken = $signed(a) >= $signed(b);
            BLTU:    e.taken = a < b;
            BGEU:    e.taken = a >= b;
            default: e.taken = 1'b1;   // JAL and JALR
        endcase
        e.rd       = rd;
        e.we       = we;
        e.data     = pc + 64'd4;                      // Link value
        e.target   = {sum[XLEN-1:1], is_cond & sum[0]};
        next       = e.taken ? e.target : pc + 64'd4;
        e.ex_valid = (next[1:0] != 2'b00) && ((op == JALR) || (is_cond && e.taken));
        e.origin   = next;
        return e;
    endfunction

    // ------------------------------------------------------------
    // Handshake rules on both outside ports
    // ------------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (reset_i) $rose(issue_ack_o) |-> issue_req_i)
        else report_error("issue_ack_o rose while issue_req_i was low");
    assert property (@(posedge clk_i) disable iff (reset_i) $fell(issue_ack_o) |-> !$past(issue_req_i))
        else report_error("issue_ack_o fell while issue_req_i was still high");
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(issue_ack_o) |-> $past(issue_req_i, 2))
        else report_error("issue_ack_o rose before the instruction could be loaded");
    assert property (@(posedge clk_i) disable iff (reset_i) $rose(wb_req_o) |-> !wb_ack_i)
        else report_error("wb_req_o rose while wb_ack_i was still high");
    assert property (@(posedge clk_i) disable iff (reset_i) $fell(wb_req_o) |-> $past(wb_ack_i))
        else report_error("wb_req_o fell before wb_ack_i rose");
    assert property (@(posedge clk_i) disable iff (reset_i)
        wb_req_o && $past(wb_req_o) |-> $stable(wb_unit_o) && $stable(wb_rd_o) && $stable(wb_we_o)
            && $stable(wb_data_o) && $stable(wb_target_o) && $stable(wb_taken_o)
            && $stable(wb_ex_valid_o) && $stable(wb_ex_cause_o) && $stable(wb_ex_origin_o))
        else report_error("writeback fields changed while wb_req_o was high");

    // ------------------------------------------------------------
    // Issue driver
    // ------------------------------------------------------------
    task automatic issue_one();
        logic [31:0]           r;
        logic [XLEN-1:0]       a, b, pc, imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        unit_t                 unit;
        op_t                   op;
        int                    cycles;
        @(posedge clk_i);
        r    = next_rand();
        unit = unit_t'(r[0]);
        rd   = r[12:8];
        we   = r[16];
        imm  = {{52{r[31]}}, r[31:21], 1'b0};   // Bit 1 random, so half land misaligned
        a    = pick_operand();
        b    = (r[3:2] == 2'b00) ? a : pick_operand();
        pc   = {next_rand(), next_rand()} & ~64'h3;
        if (unit == UNIT_ALU) begin
            op = op_t'(4'd8 + (r[7:4] % 4'd7));
            alu_q.push_back(alu_model(op, a, b, rd, we));
        end else begin
            op = op_t'({1'b0, r[6:4]});
            br_q.push_back(branch_model(op, pc, imm, a, b, rd, we));
        end
        issue_req_i      <= 1'b1;
        issue_unit_i     <= unit;
        issue_op_i       <= op;
        issue_pc_i       <= pc;
        issue_imm_i      <= imm;
        issue_rs1_data_i <= a;
        issue_rs2_data_i <= b;
        issue_rd_i       <= rd;
        issue_we_i       <= we;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) report_error("timeout waiting for issue_ack_o to rise");
        end while (!issue_ack_o);
        @(posedge clk_i);
        issue_req_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) report_error("timeout waiting for issue_ack_o to fall");
        end while (issue_ack_o);
    endtask

    // ------------------------------------------------------------
    // Writeback responder and checker
    // ------------------------------------------------------------
    task automatic check_writeback();
        exp_t e;
        if (wb_unit_o == UNIT_ALU) begin
            assert (alu_q.size() > 0) else report_error("ALU writeback with nothing outstanding");
            e = alu_q.pop_front();
        end else begin
            assert (br_q.size() > 0) else report_error("branch writeback with nothing outstanding");
            e = br_q.pop_front();
            assert (wb_target_o == e.target) else report_mismatch("wb_target_o", wb_target_o, e.target);
        end
        assert (wb_rd_o == e.rd) else report_mismatch("wb_rd_o", 64'(wb_rd_o), 64'(e.rd));
        assert (wb_we_o == e.we) else report_mismatch("wb_we_o", 64'(wb_we_o), 64'(e.we));
        assert (wb_data_o == e.data) else report_mismatch("wb_data_o", wb_data_o, e.data);
        assert (wb_taken_o == e.taken) else report_mismatch("wb_taken_o", 64'(wb_taken_o), 64'(e.taken));
        assert (wb_ex_valid_o == e.ex_valid)
            else report_mismatch("wb_ex_valid_o", 64'(wb_ex_valid_o), 64'(e.ex_valid));
        if (e.ex_valid) begin
            assert (wb_ex_cause_o == INSTR_ADDR_MISALIGNED)
                else report_mismatch("wb_ex_cause_o", 64'(wb_ex_cause_o), 64'(INSTR_ADDR_MISALIGNED));
            assert (wb_ex_origin_o == e.origin)
                else report_mismatch("wb_ex_origin_o", wb_ex_origin_o, e.origin);
        end
    endtask

    task automatic respond_all();
        int cycles;
        while (wb_count < N_INSTR) begin
            cycles = 0;
            do begin
                @(negedge clk_i);
                cycles++;
                if (cycles > TIMEOUT) report_error("timeout waiting for wb_req_o to rise");
            end while (!wb_req_o);
            check_writeback();
            repeat (next_rand() % 6) @(posedge clk_i);   // Back-pressure
            @(posedge clk_i);
            wb_ack_i <= 1'b1;
            cycles = 0;
            do begin
                @(negedge clk_i);
                cycles++;
                if (cycles > TIMEOUT) report_error("timeout waiting for wb_req_o to fall");
            end while (wb_req_o);
            @(posedge clk_i);
            wb_ack_i <= 1'b0;
            wb_count++;
        end
    endtask

    initial begin
        reset_i          = 1'b1;
        issue_req_i      = 1'b0;
        issue_unit_i     = UNIT_ALU;
        issue_op_i       = OP_ADD;
        issue_pc_i       = '0;
        issue_imm_i      = '0;
        issue_rs1_data_i = '0;
        issue_rs2_data_i = '0;
        issue_rd_i       = '0;
        issue_we_i       = 1'b0;
        wb_ack_i         = 1'b0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        assert (!issue_ack_o && !wb_req_o) else report_error("handshake outputs high after reset");
        fork
            for (int i = 0; i < N_INSTR; i++) issue_one();
            respond_all();
        join
        // Port must stay quiet once every instruction is written back
        for (int i = 0; i < QUIET; i++) begin
            @(negedge clk_i);
            if (wb_req_o) extra_wb = 1'b1;
        end
        if (extra_wb) begin
            report_error("writeback request after every instruction was written back");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* flist.f */
logic/exe_pkg.sv
logic/issue_steer.sv
logic/branch_unit.sv
logic/alu_unit.sv
logic/wb_arbiter.sv
logic/exe_top.sv
testbench/tb_exe_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exe_top -f flist.f \
    && ./obj_dir/Vtb_exe_top > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
